// File: hdl/ExecPkg.sv
package ExecPkg;

    localparam int Xlen = 32;
    localparam int XlenLog2 = 5;
    localparam int MulDivSteps = 32;

    typedef logic [Xlen-1:0] word_t;

    // mcause exception codes
    typedef logic [3:0] TrapCause;

    localparam TrapCause CauseBreakpoint = 4'd3;
    localparam TrapCause CauseEcallU = 4'd8;
    localparam TrapCause CauseEcallS = 4'd9;
    localparam TrapCause CauseEcallM = 4'd11;

    typedef enum logic [1:0] {
        ExecUnit_Alu,
        ExecUnit_Branch,
        ExecUnit_MulDiv,
        ExecUnit_Trap
    } ExecUnit;

    typedef enum logic [3:0] {
        AluCommand_Add,
        AluCommand_Sub,
        AluCommand_Sll,
        AluCommand_Slt,
        AluCommand_Sltu,
        AluCommand_Xor,
        AluCommand_Srl,
        AluCommand_Sra,
        AluCommand_Or,
        AluCommand_And
    } AluCommand;

    typedef enum logic {
        AluSrc1Type_Reg,
        AluSrc1Type_Pc
    } AluSrc1Type;

    typedef enum logic {
        AluSrc2Type_Reg,
        AluSrc2Type_Imm
    } AluSrc2Type;

    typedef enum logic [2:0] {
        BranchCond_Eq,
        BranchCond_Ne,
        BranchCond_Lt,
        BranchCond_Ge,
        BranchCond_Ltu,
        BranchCond_Geu,
        BranchCond_Always
    } BranchCond;

    typedef enum logic [2:0] {
        MulDivCommand_Mul,
        MulDivCommand_Mulhu,
        MulDivCommand_Div,
        MulDivCommand_Divu,
        MulDivCommand_Rem,
        MulDivCommand_Remu
    } MulDivCommand;

    typedef enum logic {
        TrapOp_Ecall,
        TrapOp_Ebreak
    } TrapOp;

    typedef enum logic [1:0] {
        Privilege_User = 2'd0,
        Privilege_Supervisor = 2'd1,
        Privilege_Machine = 2'd3
    } Privilege;

    typedef struct packed {
        logic indirect;
        BranchCond cond;
    } BranchCommand;

    typedef struct packed {
        logic pad;
        MulDivCommand command;
    } MulDivCommandWord;

    typedef struct packed {
        logic [2:0] pad;
        TrapOp op;
    } TrapCommand;

    // view is picked by the unit field of the operation
    typedef union packed {
        AluCommand alu;
        BranchCommand branch;
        MulDivCommandWord mulDiv;
        TrapCommand trap;
    } CommandWord;

endpackage

// File: hdl/IntAlu.sv
`timescale 1ns/1ps

module IntAlu (
    input ExecPkg::AluSrc1Type src1Type,
    input ExecPkg::AluSrc2Type src2Type,
    input ExecPkg::AluCommand command,
    input ExecPkg::word_t pc,
    input ExecPkg::word_t rs1Value,
    input ExecPkg::word_t rs2Value,
    input ExecPkg::word_t imm,
    output ExecPkg::word_t result
);
    import ExecPkg::*;

    word_t operand1;
    word_t operand2;
    logic [XlenLog2-1:0] shamt;

    // operand muxes
    always_comb begin
        operand1 = (src1Type == AluSrc1Type_Pc) ? pc : rs1Value;
        operand2 = (src2Type == AluSrc2Type_Imm) ? imm : rs2Value;
        shamt = operand2[XlenLog2-1:0];
    end

    always_comb begin
        case (command)
            AluCommand_Add: begin
                result = operand1 + operand2;
            end
            AluCommand_Sub: begin
                result = operand1 - operand2;
            end
            AluCommand_Sll: begin
                result = operand1 << shamt;
            end
            AluCommand_Slt: begin
                result = word_t'($signed(operand1) < $signed(operand2));
            end
            AluCommand_Sltu: begin
                result = word_t'(operand1 < operand2);
            end
            AluCommand_Xor: begin
                result = operand1 ^ operand2;
            end
            AluCommand_Srl: begin
                result = operand1 >> shamt;
            end
            AluCommand_Sra: begin
                // arithmetic shift keeps the sign bit
                result = word_t'($signed(operand1) >>> shamt);
            end
            AluCommand_Or: begin
                result = operand1 | operand2;
            end
            AluCommand_And: begin
                result = operand1 & operand2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: hdl/BranchUnit.sv
`timescale 1ns/1ps

module BranchUnit (
    input ExecPkg::BranchCond cond,
    input logic indirect,
    input ExecPkg::word_t pc,
    input ExecPkg::word_t rs1Value,
    input ExecPkg::word_t rs2Value,
    input ExecPkg::word_t imm,
    output logic taken,
    output ExecPkg::word_t target
);
    import ExecPkg::*;

    logic equal;
    logic lessSigned;
    logic lessUnsigned;
    word_t indirectSum;

    always_comb begin
        equal = (rs1Value == rs2Value);
        lessSigned = $signed(rs1Value) < $signed(rs2Value);
        lessUnsigned = rs1Value < rs2Value;

        case (cond)
            BranchCond_Eq:     taken = equal;
            BranchCond_Ne:     taken = !equal;
            BranchCond_Lt:     taken = lessSigned;
            BranchCond_Ge:     taken = !lessSigned;
            BranchCond_Ltu:    taken = lessUnsigned;
            BranchCond_Geu:    taken = !lessUnsigned;
            BranchCond_Always: taken = 1'b1;
            default:           taken = 1'b0;
        endcase
    end

    // jalr clears bit 0 of the sum
    always_comb begin
        indirectSum = rs1Value + imm;
        target = indirect ? {indirectSum[Xlen-1:1], 1'b0} : pc + imm;
    end

endmodule

// File: hdl/MulDivUnit.sv
`timescale 1ns/1ps

module MulDivUnit (
    input logic clk,
    input logic rst,
    input logic enable,
    input logic take,
    input ExecPkg::MulDivCommand command,
    input ExecPkg::word_t src1,
    input ExecPkg::word_t src2,
    output logic done,
    output ExecPkg::word_t result
);
    import ExecPkg::*;

    logic busy;
    logic start;
    logic [$clog2(MulDivSteps)-1:0] step;

    MulDivCommand commandReg;
    logic negateQuotient;
    logic negateRemainder;
    // product high half or partial remainder
    word_t hiReg;
    // multiplier or quotient, shifted one bit per step
    word_t loReg;
    word_t operandReg;

    logic isSigned;
    logic isDivide;
    word_t magnitude1;
    word_t magnitude2;
    logic [Xlen:0] addSum;
    logic [Xlen:0] shifted;
    logic [Xlen+1:0] difference;

    always_comb begin
        start = enable && !busy && !done;
        isSigned = command inside {MulDivCommand_Div, MulDivCommand_Rem};
        isDivide = commandReg inside {MulDivCommand_Div, MulDivCommand_Divu,
                                      MulDivCommand_Rem, MulDivCommand_Remu};
        magnitude1 = (isSigned && src1[Xlen-1]) ? -src1 : src1;
        magnitude2 = (isSigned && src2[Xlen-1]) ? -src2 : src2;

        addSum = {1'b0, hiReg} + (loReg[0] ? {1'b0, operandReg} : '0);
        shifted = {hiReg, loReg[Xlen-1]};
        difference = {1'b0, shifted} - {2'b0, operandReg};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= 1'b0;
            done <= 1'b0;
            step <= '0;
        end
        else if (busy) begin
            step <= step + 1'b1;
            if (step == MulDivSteps - 1) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
        else if (done) begin
            if (take) begin
                done <= 1'b0;
            end
        end
        else if (enable) begin
            busy <= 1'b1;
            step <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            commandReg <= command;
            // x/0 keeps the quotient all ones
            negateQuotient <= isSigned && (src1[Xlen-1] ^ src2[Xlen-1]) && (src2 != '0);
            negateRemainder <= isSigned && src1[Xlen-1];
            hiReg <= '0;
            loReg <= magnitude1;
            operandReg <= magnitude2;
        end
        else if (busy) begin
            if (isDivide) begin
                if (!difference[Xlen+1]) begin
                    hiReg <= difference[Xlen-1:0];
                    loReg <= {loReg[Xlen-2:0], 1'b1};
                end
                else begin
                    hiReg <= shifted[Xlen-1:0];
                    loReg <= {loReg[Xlen-2:0], 1'b0};
                end
            end
            else begin
                hiReg <= addSum[Xlen:1];
                loReg <= {addSum[0], loReg[Xlen-1:1]};
            end
        end
    end

    // signs go back on after the magnitude loop
    always_comb begin
        case (commandReg)
            MulDivCommand_Mul:   result = loReg;
            MulDivCommand_Mulhu: result = hiReg;
            MulDivCommand_Div,
            MulDivCommand_Divu:  result = negateQuotient ? -loReg : loReg;
            default:             result = negateRemainder ? -hiReg : hiReg;
        endcase
    end

    // producer holds the operation until it is accepted
    assert property (@(posedge clk) disable iff (rst)
        enable && !done |=> $stable(command) && $stable(src1) && $stable(src2))
        else $error("muldiv operands changed while in flight");

    assert property (@(posedge clk) disable iff (rst) take |-> done)
        else $error("muldiv take without done");

endmodule

// File: hdl/TrapCheck.sv
`timescale 1ns/1ps

module TrapCheck (
    input logic active,
    input ExecPkg::TrapOp op,
    input ExecPkg::Privilege privilege,
    output logic trap,
    output ExecPkg::TrapCause cause
);
    import ExecPkg::*;

    always_comb begin
        trap = active;

        if (op == TrapOp_Ebreak) begin
            cause = CauseBreakpoint;
        end
        else begin
            // ecall cause follows the current mode
            case (privilege)
                Privilege_Machine: begin
                    cause = CauseEcallM;
                end
                Privilege_Supervisor: begin
                    cause = CauseEcallS;
                end
                default: begin
                    cause = CauseEcallU;
                end
            endcase
        end
    end

endmodule

// File: hdl/ExecuteStage.sv
`timescale 1ns/1ps

module ExecuteStage (
    input logic clk,
    input logic rst,
    input logic inValid,
    input ExecPkg::ExecUnit unit,
    input ExecPkg::CommandWord command,
    input ExecPkg::AluSrc1Type src1Type,
    input ExecPkg::AluSrc2Type src2Type,
    input logic isCompressed,
    input ExecPkg::word_t pc,
    input ExecPkg::word_t imm,
    input ExecPkg::word_t rs1Value,
    input ExecPkg::word_t rs2Value,
    input ExecPkg::Privilege privilege,
    input logic outReady,
    output logic inReady,
    output logic outValid,
    output ExecPkg::word_t outPc,
    output ExecPkg::word_t rdValue,
    output logic flushValid,
    output ExecPkg::word_t flushTarget,
    output logic trapValid,
    output ExecPkg::TrapCause trapCause
);
    import ExecPkg::*;

    logic slotFree;
    logic isMulDiv;
    logic accept;
    logic mulDivEnable;
    logic mulDivDone;
    logic mulDivTake;
    logic trapActive;
    word_t aluResult;
    word_t mulDivResult;
    logic branchTaken;
    word_t branchTarget;
    logic trapRaised;
    TrapCause trapCode;
    word_t nextRdValue;
    logic nextFlush;
    word_t nextFlushTarget;

    // handshake
    always_comb begin
        slotFree = !outValid || outReady;
        isMulDiv = (unit == ExecUnit_MulDiv);
        mulDivEnable = inValid && isMulDiv;
        trapActive = inValid && (unit == ExecUnit_Trap);
        inReady = slotFree && (!isMulDiv || mulDivDone);
        accept = inValid && inReady;
        mulDivTake = accept && isMulDiv;
    end

    IntAlu intAlu (
        .src1Type(src1Type),
        .src2Type(src2Type),
        .command(command.alu),
        .pc(pc),
        .rs1Value(rs1Value),
        .rs2Value(rs2Value),
        .imm(imm),
        .result(aluResult)
    );

    BranchUnit branchUnit (
        .cond(command.branch.cond),
        .indirect(command.branch.indirect),
        .pc(pc),
        .rs1Value(rs1Value),
        .rs2Value(rs2Value),
        .imm(imm),
        .taken(branchTaken),
        .target(branchTarget)
    );

    MulDivUnit mulDivUnit (
        .clk(clk),
        .rst(rst),
        .enable(mulDivEnable),
        .take(mulDivTake),
        .command(command.mulDiv.command),
        .src1(rs1Value),
        .src2(rs2Value),
        .done(mulDivDone),
        .result(mulDivResult)
    );

    TrapCheck trapCheck (
        .active(trapActive),
        .op(command.trap.op),
        .privilege(privilege),
        .trap(trapRaised),
        .cause(trapCode)
    );

    // result select
    always_comb begin
        nextFlush = 1'b0;
        nextFlushTarget = '0;
        case (unit)
            ExecUnit_Alu: begin
                nextRdValue = aluResult;
            end
            ExecUnit_Branch: begin
                // link value
                nextRdValue = pc + (isCompressed ? word_t'(2) : word_t'(4));
                nextFlush = branchTaken;
                if (branchTaken) begin
                    nextFlushTarget = branchTarget;
                end
            end
            ExecUnit_MulDiv: begin
                nextRdValue = mulDivResult;
            end
            default: begin
                nextRdValue = '0;
                nextFlush = trapRaised;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            flushValid <= 1'b0;
            trapValid <= 1'b0;
        end
        else if (accept) begin
            outValid <= 1'b1;
            flushValid <= nextFlush;
            trapValid <= trapRaised;
        end
        else if (outReady) begin
            outValid <= 1'b0;
            flushValid <= 1'b0;
            trapValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            outPc <= pc;
            rdValue <= nextRdValue;
            flushTarget <= nextFlushTarget;
            trapCause <= trapRaised ? trapCode : '0;
        end
    end

    // held slot must not change until the consumer takes it
    assert property (@(posedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outPc) && $stable(rdValue)
            && $stable(flushValid) && $stable(flushTarget)
            && $stable(trapValid) && $stable(trapCause))
        else $error("output slot changed under back-pressure");

endmodule

// File: sim/ExecuteStageTb.sv
`timescale 1ns/1ps

module ExecuteStageTb;
    import ExecPkg::*;

    localparam int ClockPeriod = 4;
    localparam int AluOps = 40;
    localparam int BranchOps = 28;
    localparam int MulDivDirectedOps = 8;
    localparam int MulDivRandomOps = 16;
    localparam int TrapOps = 12;
    localparam int MixedOps = 40;
    localparam int TotalOps = AluOps + BranchOps + MulDivDirectedOps + MulDivRandomOps
        + TrapOps + MixedOps;
    // every op budgeted as a full multiply/divide
    localparam int WatchdogNs = TotalOps * (MulDivSteps + 4) * ClockPeriod + 400 * ClockPeriod;

    typedef struct packed {
        word_t pc;
        word_t rd;
        logic flush;
        word_t target;
        logic trap;
        TrapCause cause;
    } ExpectedOut;

    logic clk;
    logic rst;
    logic inValid;
    ExecUnit unit;
    CommandWord command;
    AluSrc1Type src1Type;
    AluSrc2Type src2Type;
    logic isCompressed;
    word_t pc;
    word_t imm;
    word_t rs1Value;
    word_t rs2Value;
    Privilege privilege;
    logic outReady;
    logic inReady;
    logic outValid;
    word_t outPc;
    word_t rdValue;
    logic flushValid;
    word_t flushTarget;
    logic trapValid;
    TrapCause trapCause;
    logic outFire;

    ExpectedOut expQ[$];
    ExpectedOut head;
    logic headValid = 1'b0;
    Privilege privileges[3] = '{Privilege_User, Privilege_Supervisor, Privilege_Machine};
    int opCount = 0;
    int errorCount = 0;
    int checkedCount = 0;
    int testCount = 0;
    int failedTests = 0;
    int testErrorsAtStart = 0;
    int testCheckedAtStart = 0;

    ExecuteStage i_ExecuteStage (
        .clk(clk),
        .rst(rst),
        .inValid(inValid),
        .unit(unit),
        .command(command),
        .src1Type(src1Type),
        .src2Type(src2Type),
        .isCompressed(isCompressed),
        .pc(pc),
        .imm(imm),
        .rs1Value(rs1Value),
        .rs2Value(rs2Value),
        .privilege(privilege),
        .outReady(outReady),
        .inReady(inReady),
        .outValid(outValid),
        .outPc(outPc),
        .rdValue(rdValue),
        .flushValid(flushValid),
        .flushTarget(flushTarget),
        .trapValid(trapValid),
        .trapCause(trapCause)
    );

    assign outFire = outValid && outReady;

    initial begin
        clk = 1'b0;
        forever #(ClockPeriod / 2) clk = ~clk;
    end

    initial begin
        #(WatchdogNs);
        $display("timeout: run did not finish within %0d ns", WatchdogNs);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic reportMismatch(string message);
        errorCount++;
        $display("MISMATCH at time %0t: %s", $time, message);
    endtask

    task automatic reportError(string message);
        errorCount++;
        $display("error at time %0t: %s", $time, message);
    endtask

    // signed compare by flipping the sign bit
    function automatic logic lessSignedRef(word_t a, word_t b);
        return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
    endfunction

    function automatic word_t aluRef(AluCommand cmd, word_t a, word_t b);
        logic [XlenLog2-1:0] sh;
        sh = b[XlenLog2-1:0];
        case (cmd)
            AluCommand_Add: return a + b;
            AluCommand_Sub: return a - b;
            AluCommand_Sll: return a << sh;
            AluCommand_Slt: return {31'b0, lessSignedRef(a, b)};
            AluCommand_Sltu: return {31'b0, a < b};
            AluCommand_Xor: return a ^ b;
            AluCommand_Srl: return a >> sh;
            AluCommand_Sra: return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            AluCommand_Or: return a | b;
            AluCommand_And: return a & b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic branchTakenRef(BranchCond cond, word_t a, word_t b);
        case (cond)
            BranchCond_Eq: return a == b;
            BranchCond_Ne: return a != b;
            BranchCond_Lt: return lessSignedRef(a, b);
            BranchCond_Ge: return !lessSignedRef(a, b);
            BranchCond_Ltu: return a < b;
            BranchCond_Geu: return a >= b;
            default: return 1'b1;
        endcase
    endfunction

    function automatic word_t mulDivRef(MulDivCommand cmd, word_t a, word_t b);
        logic [63:0] product;
        logic overflow;
        product = {32'h0, a} * {32'h0, b};
        overflow = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        case (cmd)
            MulDivCommand_Mul: return product[31:0];
            MulDivCommand_Mulhu: return product[63:32];
            MulDivCommand_Divu: return (b == 32'h0) ? 32'hffff_ffff : a / b;
            MulDivCommand_Remu: return (b == 32'h0) ? a : a % b;
            MulDivCommand_Div: begin
                if (b == 32'h0) return 32'hffff_ffff;
                if (overflow) return a;
                return word_t'($signed(a) / $signed(b));
            end
            default: begin
                if (b == 32'h0) return a;
                if (overflow) return 32'h0;
                return word_t'($signed(a) % $signed(b));
            end
        endcase
    endfunction

    function automatic TrapCause trapCauseRef(TrapOp op, Privilege priv);
        if (op == TrapOp_Ebreak) return 4'd3;
        if (priv == Privilege_Machine) return 4'd11;
        if (priv == Privilege_Supervisor) return 4'd9;
        return 4'd8;
    endfunction

    function automatic ExpectedOut expectedFor();
        ExpectedOut e;
        word_t a;
        word_t b;
        e = '0;
        e.pc = pc;
        a = (src1Type == AluSrc1Type_Pc) ? pc : rs1Value;
        b = (src2Type == AluSrc2Type_Imm) ? imm : rs2Value;
        case (unit)
            ExecUnit_Alu: begin
                e.rd = aluRef(command.alu, a, b);
            end
            ExecUnit_Branch: begin
                e.rd = pc + (isCompressed ? 32'd2 : 32'd4);
                e.flush = branchTakenRef(command.branch.cond, rs1Value, rs2Value);
                if (e.flush) begin
                    e.target = command.branch.indirect ? ((rs1Value + imm) & ~32'h1) : pc + imm;
                end
            end
            ExecUnit_MulDiv: begin
                e.rd = mulDivRef(command.mulDiv.command, rs1Value, rs2Value);
            end
            default: begin
                e.flush = 1'b1;
                e.trap = 1'b1;
                e.cause = trapCauseRef(command.trap.op, privilege);
            end
        endcase
        return e;
    endfunction

    // scoreboard runs on pre-edge values, checks sample at the falling edge
    always @(posedge clk) begin
        if (rst) begin
            expQ.delete();
        end
        else begin
            if (outFire && expQ.size() > 0) begin
                void'(expQ.pop_front());
                checkedCount++;
            end
            if (inValid && inReady) begin
                expQ.push_back(expectedFor());
            end
        end
        headValid = expQ.size() > 0;
        head = headValid ? expQ[0] : '0;
    end

    assert property (@(negedge clk) disable iff (rst) outFire |-> headValid)
        else reportError("output transfer with no operation pending");

    assert property (@(negedge clk) disable iff (rst) outFire && headValid |-> outPc == head.pc)
        else reportMismatch($sformatf("outPc %h, expected %h", outPc, head.pc));

    assert property (@(negedge clk) disable iff (rst) outFire && headValid |-> rdValue == head.rd)
        else reportMismatch($sformatf("pc %h rdValue %h, expected %h", outPc, rdValue, head.rd));

    assert property (@(negedge clk) disable iff (rst)
        outFire && headValid |-> flushValid == head.flush)
        else reportMismatch($sformatf("pc %h flushValid %b, expected %b",
            outPc, flushValid, head.flush));

    assert property (@(negedge clk) disable iff (rst)
        outFire && headValid && head.flush && !head.trap |-> flushTarget == head.target)
        else reportMismatch($sformatf("pc %h flushTarget %h, expected %h",
            outPc, flushTarget, head.target));

    assert property (@(negedge clk) disable iff (rst)
        outFire && headValid |-> trapValid == head.trap && (!head.trap || trapCause == head.cause))
        else reportMismatch($sformatf("pc %h trap %b cause %0d, expected %b cause %0d",
            outPc, trapValid, trapCause, head.trap, head.cause));

    assert property (@(negedge clk) disable iff (rst)
        outValid && !outReady |=> outValid && $stable(outPc) && $stable(rdValue)
            && $stable(flushValid) && $stable(flushTarget)
            && $stable(trapValid) && $stable(trapCause))
        else reportError("output slot changed while outReady was low");

    task automatic driveReady();
        forever begin
            @(posedge clk);
            #1;
            outReady = ($urandom % 4) != 0;
        end
    endtask

    // hold the operation until the stage takes it
    task automatic transfer();
        logic accepted;
        pc = 32'h0001_0000 + word_t'(opCount * 4);
        inValid = 1'b1;
        opCount++;
        do begin
            @(negedge clk);
            accepted = inReady;
            @(posedge clk);
            #1;
        end while (!accepted);
        inValid = 1'b0;
    endtask

    task automatic sendAlu(AluCommand cmd, AluSrc1Type s1, AluSrc2Type s2);
        unit = ExecUnit_Alu;
        command = '0;
        command.alu = cmd;
        src1Type = s1;
        src2Type = s2;
        rs1Value = $urandom;
        rs2Value = $urandom;
        imm = $urandom;
        transfer();
    endtask

    task automatic sendBranch(BranchCond cond, logic indirect);
        unit = ExecUnit_Branch;
        command = '0;
        command.branch.cond = cond;
        command.branch.indirect = indirect;
        rs1Value = $urandom;
        rs2Value = (($urandom % 4) == 0) ? rs1Value : $urandom;
        imm = word_t'($urandom % 4096) - 32'd2048;
        isCompressed = ($urandom % 2) == 1;
        transfer();
    endtask

    task automatic sendMulDiv(MulDivCommand cmd, word_t a, word_t b);
        unit = ExecUnit_MulDiv;
        command = '0;
        command.mulDiv.command = cmd;
        rs1Value = a;
        rs2Value = b;
        transfer();
    endtask

    task automatic sendTrap(TrapOp op, Privilege priv);
        unit = ExecUnit_Trap;
        command = '0;
        command.trap.op = op;
        privilege = priv;
        transfer();
    endtask

    task automatic startTest();
        testErrorsAtStart = errorCount;
        testCheckedAtStart = checkedCount;
    endtask

    // wait out the queue, then a few idle cycles for stray outputs
    task automatic endTest(string name);
        while (expQ.size() != 0) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
        @(posedge clk);
        #1;
        testCount++;
        if (errorCount == testErrorsAtStart) begin
            $display("test %s: ok, %0d outputs checked", name, checkedCount - testCheckedAtStart);
        end
        else begin
            failedTests++;
            $display("test %s: failed, %0d errors", name, errorCount - testErrorsAtStart);
        end
    endtask

    initial begin
        rst = 1'b1;
        inValid = 1'b0;
        unit = ExecUnit_Alu;
        command = '0;
        src1Type = AluSrc1Type_Reg;
        src2Type = AluSrc2Type_Reg;
        isCompressed = 1'b0;
        pc = '0;
        imm = '0;
        rs1Value = '0;
        rs2Value = '0;
        privilege = Privilege_Machine;
        outReady = 1'b0;
        void'($urandom(45));

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        startTest();
        assert (!outValid && !flushValid && !trapValid)
            else reportError("output slot not empty after reset");
        endTest("reset");
        fork
            driveReady();
        join_none

        startTest();
        for (int i = 0; i < AluOps; i++) begin
            sendAlu(AluCommand'(i % 10), AluSrc1Type'($urandom % 2), AluSrc2Type'($urandom % 2));
        end
        endTest("alu");

        startTest();
        for (int i = 0; i < BranchOps; i++) begin
            sendBranch(BranchCond'(i % 7), ($urandom % 2) == 1);
        end
        endTest("branch");

        startTest();
        for (int c = 0; c < 6; c++) begin
            sendMulDiv(MulDivCommand'(c), $urandom, 32'h0);
        end
        sendMulDiv(MulDivCommand_Div, 32'h8000_0000, 32'hffff_ffff);
        sendMulDiv(MulDivCommand_Rem, 32'h8000_0000, 32'hffff_ffff);
        for (int i = 0; i < MulDivRandomOps; i++) begin
            // small divisors of either sign, zero included
            sendMulDiv(MulDivCommand'(i % 6), $urandom,
                ((i % 3) == 0) ? word_t'($urandom % 13) - 32'd6 : $urandom);
        end
        endTest("muldiv");

        startTest();
        for (int i = 0; i < TrapOps; i++) begin
            sendTrap((i % 2) == 1 ? TrapOp_Ebreak : TrapOp_Ecall, privileges[(i / 2) % 3]);
        end
        endTest("trap");

        startTest();
        for (int i = 0; i < MixedOps; i++) begin
            case ($urandom % 4)
                0: sendAlu(AluCommand'($urandom % 10), AluSrc1Type'($urandom % 2),
                    AluSrc2Type'($urandom % 2));
                1: sendBranch(BranchCond'($urandom % 7), ($urandom % 2) == 1);
                2: sendMulDiv(MulDivCommand'($urandom % 6), $urandom, $urandom % 64);
                default: sendTrap(TrapOp'($urandom % 2), privileges[$urandom % 3]);
            endcase
            if (($urandom % 8) == 0) begin
                @(posedge clk);
                #1;
            end
        end
        endTest("mixed handshake");

        $display("%0d tests, %0d failed, %0d outputs checked, %0d errors",
            testCount, failedTests, checkedCount, errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end
        else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: execStage.f
hdl/ExecPkg.sv
hdl/IntAlu.sv
hdl/BranchUnit.sv
hdl/MulDivUnit.sv
hdl/TrapCheck.sv
hdl/ExecuteStage.sv
sim/ExecuteStageTb.sv

// File: runSim.sh
#!/bin/sh
# builds and runs the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module ExecuteStageTb -f execStage.f -o ExecuteStageTb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/ExecuteStageTb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx '=== PASS ==='; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1
